// ==== Makefile ====
SIM = obj_dir/video_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module video_tb \
		-f flist.f -o video_sim

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== flist.f ====
logic/video_pkg.sv
logic/video_regs.sv
logic/video_raster.sv
logic/video_mode.sv
logic/video_fetch.sv
logic/video_top.sv
verification/tb_clock.sv
verification/video_tb.sv

// ==== logic/video_fetch.sv ====
// fetch scheduler: paces dram reads inside the fetch window and keeps the fetch counters
module video_fetch (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [8:0]  hcount,
    input  logic [8:0]  vcount,
    input  logic        line_start,
    input  logic [8:0]  hpix_beg,
    input  logic [8:0]  hpix_end,
    input  logic [8:0]  vpix_beg,
    input  logic [8:0]  vpix_end,
    input  logic [4:0]  go_offs,
    input  logic [3:0]  video_bw,
    input  logic [20:0] video_addr,
    input  logic [3:0]  fetch_sel,
    input  logic [1:0]  fetch_bsl,
    input  logic [15:0] dram_data,
    input  logic        dram_rdy,
    output logic [8:0]  cnt_col,
    output logic [8:0]  cnt_row,
    output logic [15:0] txt_char,
    output logic        pix_active,
    output logic        dram_req,
    output logic [20:0] dram_addr,
    output logic [3:0]  dram_sel,
    output logic [1:0]  dram_bsl
);

    logic [8:0]  win_beg;
    logic [8:0]  win_end;
    logic        line_on;
    logic        in_win;
    logic [2:0]  slot_cnt;  // position in the bandwidth period
    logic [2:0]  slot_pos;
    logic        slot_go;
    logic        char_wait;  // char code read is in flight
    logic        char_back;
    logic [15:0] char_q;

    assign win_beg = hpix_beg - {4'd0, go_offs};
    assign win_end = hpix_end - {4'd0, go_offs};
    assign line_on = (vcount >= vpix_beg) && (vcount < vpix_end);
    assign in_win  = line_on && (hcount >= win_beg) && (hcount < win_end);

    assign slot_pos = video_bw[3] ? slot_cnt : {1'b0, slot_cnt[1:0]};

    // requests take the first slots of each period
    always_comb begin
        case (video_bw[2:0])
            3'b001:  slot_go = in_win && (slot_pos == 3'd0);
            3'b010:  slot_go = in_win && (slot_pos < 3'd2);
            3'b100:  slot_go = in_win && (slot_pos < 3'd4);
            default: slot_go = in_win;  // 000, all cycles
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_cnt  <= 3'd0;
            cnt_col   <= 9'd0;
            dram_req  <= 1'b0;
            char_wait <= 1'b0;
        end else begin
            slot_cnt <= in_win ? slot_cnt + 3'd1 : 3'd0;
            if (line_start) begin
                cnt_col <= 9'd0;
            end else if (slot_go) begin
                cnt_col <= cnt_col + 9'd1;
            end
            dram_req  <= slot_go;
            char_wait <= dram_req && (dram_sel == 4'b0011);  // char code selector
        end
    end

    always_ff @(posedge clk) begin
        if (slot_go) begin
            dram_addr <= video_addr;
        end
        if (char_back) begin
            char_q <= dram_data;
        end
    end

    // returning char code goes straight on so the glyph fetch can follow at once
    assign char_back = dram_rdy && char_wait;
    assign txt_char  = char_back ? dram_data : char_q;

    assign dram_sel = fetch_sel;
    assign dram_bsl = fetch_bsl;

    assign cnt_row    = vcount - vpix_beg;
    assign pix_active = line_on && (hcount >= hpix_beg) && (hcount < hpix_end);

endmodule

// ==== logic/video_mode.sv ====
// video mode decoder: window, fetch offset, bandwidth, render mode and per-fetch address
module video_mode
    import video_pkg::*;
(
    input  logic [7:0]  vconfig,
    input  logic [7:0]  scr_page,
    input  logic [15:0] txt_char,
    input  logic [8:0]  cnt_col,
    input  logic [8:0]  cnt_row,
    output logic [8:0]  hpix_beg,
    output logic [8:0]  hpix_end,
    output logic [8:0]  vpix_beg,
    output logic [8:0]  vpix_end,
    output logic [4:0]  go_offs,
    output logic [3:0]  fetch_sel,
    output logic [1:0]  fetch_bsl,
    output logic        hires,
    output logic [1:0]  render_mode,
    output logic [20:0] video_addr,
    output logic [3:0]  video_bw
);

    logic [2:0]  vmod;
    logic [1:0]  rres;
    logic [11:0] addr_zx_gfx;
    logic [11:0] addr_zx_atr;
    logic [20:0] addr_zx;
    logic [20:0] addr_16c;
    logic [20:0] addr_256c;
    logic [13:0] addr_tx;
    logic [20:0] addr_text;

    assign vmod = vconfig[2:0];
    assign rres = vconfig[4:3];

    // raster window from resolution
    assign hpix_beg = hp_beg_tab[rres];
    assign hpix_end = hp_end_tab[rres];
    assign vpix_beg = vp_beg_tab[rres];
    assign vpix_end = vp_end_tab[rres];

    // fetch lead ahead of the pixel window, values found on hardware
    always_comb begin
        case (vmod)
            m_zx, m_gs, m_03, m_04: go_offs = 5'd18;
            m_02, m_hc, m_tx:       go_offs = 5'd10;
            m_xc:                   go_offs = 5'd6;
            default:                go_offs = 5'd18;
        endcase
    end

    // bw[3] selects an 8 cycle period, bw[2:0] the fetches in it
    always_comb begin
        case (vmod)
            m_zx:             video_bw = 4'b1001;  // 1 of 8
            m_gs, m_02, m_hc: video_bw = 4'b1010;  // 2 of 8
            m_03, m_tx:       video_bw = 4'b1100;  // 4 of 8
            m_04:             video_bw = 4'b0000;  // every cycle
            m_xc:             video_bw = 4'b0010;  // 2 of 4
            default:          video_bw = 4'b1001;
        endcase
    end

    assign hires = (vmod == m_02) || (vmod == m_tx);  // double pixel rate

    always_comb begin
        case (vmod)
            m_hc:    render_mode = r_hc;
            m_xc:    render_mode = r_xc;
            m_03:    render_mode = r_03;  // test renderer path
            default: render_mode = r_zx;
        endcase
    end

    // zx: even column is bitmap, odd column is attribute
    assign addr_zx_gfx = {cnt_row[7:6], cnt_row[2:0], cnt_row[5:3], cnt_col[4:1]};
    assign addr_zx_atr = {3'b110, cnt_row[7:3], cnt_col[4:1]};
    assign addr_zx     = {scr_page, 1'b0, cnt_col[0] ? addr_zx_atr : addr_zx_gfx};

    // linear modes
    assign addr_16c  = {scr_page[7:3], cnt_row, cnt_col[6:0]};
    assign addr_256c = {scr_page[7:4], cnt_row, cnt_col[7:0]};

    // text: char code, attribute, then both glyph rows of the fetched char pair
    always_comb begin
        case (cnt_col[1:0])
            2'd0:    addr_tx = {1'b0, cnt_row[8:3], 1'b0, cnt_col[7:2]};
            2'd1:    addr_tx = {1'b0, cnt_row[8:3], 1'b1, cnt_col[7:2]};
            2'd2:    addr_tx = {4'b1000, txt_char[7:0], cnt_row[2:1]};
            default: addr_tx = {4'b1000, txt_char[15:8], cnt_row[2:1]};
        endcase
    end
    assign addr_text = {scr_page[7:1], addr_tx};

    always_comb begin
        case (vmod)
            m_gs:    video_addr = 21'd0;  // gigascreen not addressed
            m_hc:    video_addr = addr_16c;
            m_xc:    video_addr = addr_256c;
            m_tx:    video_addr = addr_text;
            default: video_addr = addr_zx;  // zx and test modes
        endcase
    end

    // selectors are read in the request cycle, column already advanced by one
    always_comb begin
        if (vmod == m_tx) begin
            case (cnt_col[1:0])
                2'd1: begin
                    fetch_sel = 4'b0011;  // char code
                    fetch_bsl = 2'b10;
                end
                2'd2: begin
                    fetch_sel = 4'b1100;  // attribute
                    fetch_bsl = 2'b10;
                end
                2'd3: begin
                    fetch_sel = 4'b0001;  // glyph 0
                    fetch_bsl = {2{cnt_row[0]}};
                end
                default: begin
                    fetch_sel = 4'b0010;  // glyph 1
                    fetch_bsl = {2{cnt_row[0]}};
                end
            endcase
        end else begin
            fetch_sel = {{2{~cnt_col[0]}}, {2{cnt_col[0]}}};
            fetch_bsl = 2'b10;
        end
    end

endmodule

// ==== logic/video_pkg.sv ====
// shared video constants; modules pull them in with a wildcard import in their header
package video_pkg;

    // video modes, config bits 2:0
    localparam logic [2:0] m_zx = 3'h0;  // zx screen
    localparam logic [2:0] m_gs = 3'h1;  // gigascreen, address stays zero
    localparam logic [2:0] m_02 = 3'h2;  // zx hi-res test
    localparam logic [2:0] m_03 = 3'h3;  // test
    localparam logic [2:0] m_04 = 3'h4;  // test, full bandwidth
    localparam logic [2:0] m_hc = 3'h5;  // 16 colours
    localparam logic [2:0] m_xc = 3'h6;  // 256 colours
    localparam logic [2:0] m_tx = 3'h7;  // text

    // render modes seen by the pixel renderer
    localparam logic [1:0] r_zx = 2'h0;
    localparam logic [1:0] r_hc = 2'h1;
    localparam logic [1:0] r_xc = 2'h2;
    localparam logic [1:0] r_03 = 2'h3;

    // raster window per resolution, config bits 4:3
    // index 0 256x192, 1 320x200, 2 320x240, 3 360x288
    localparam logic [8:0] hp_beg_tab [0:3] = '{
        9'd140,  // 88 blank + 52 border
        9'd108,
        9'd108,
        9'd88    // no border
    };
    localparam logic [8:0] hp_end_tab [0:3] = '{
        9'd396,
        9'd428,
        9'd428,
        9'd448
    };
    localparam logic [8:0] vp_beg_tab [0:3] = '{
        9'd80,   // 32 blank + 48 border
        9'd76,
        9'd56,
        9'd32
    };
    localparam logic [8:0] vp_end_tab [0:3] = '{
        9'd272,
        9'd276,
        9'd296,
        9'd320
    };

    // frame size in pixel clocks and lines
    localparam logic [8:0] h_total = 9'd448;
    localparam logic [8:0] v_total = 9'd320;

    // cpu register map
    localparam logic reg_vconfig  = 1'b0;
    localparam logic reg_scr_page = 1'b1;

endpackage

// ==== logic/video_raster.sv ====
// raster timing for the 448x320 frame, gives pixel and line counts plus start strobes
module video_raster
    import video_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    output logic [8:0] hcount,
    output logic [8:0] vcount,
    output logic       line_start,
    output logic       frame_start
);

    logic h_last;
    logic v_last;

    assign h_last = (hcount == h_total - 9'd1);  // pixel 447
    assign v_last = (vcount == v_total - 9'd1);  // line 319

    // horizontal pixel counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hcount <= 9'd0;
        end else if (h_last) begin
            hcount <= 9'd0;
        end else begin
            hcount <= hcount + 9'd1;
        end
    end

    // line counter, steps once per wrap of hcount
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vcount <= 9'd0;
        end else if (h_last) begin
            if (v_last) begin
                vcount <= 9'd0;
            end else begin
                vcount <= vcount + 9'd1;
            end
        end
    end

    // strobes decoded straight from the counters
    assign line_start  = (hcount == 9'd0);
    assign frame_start = line_start && (vcount == 9'd0);

endmodule

// ==== logic/video_regs.sv ====
// cpu-visible video config and page registers, applied to the video path at frame start
module video_regs
    import video_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       reg_wr,
    input  logic       reg_addr,
    input  logic [7:0] reg_data,
    input  logic       frame_start,
    output logic [7:0] vconfig,
    output logic [7:0] scr_page
);

    logic [7:0] vconfig_stg;  // written by cpu, not yet live
    logic [7:0] page_stg;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vconfig_stg <= 8'h00;
            page_stg    <= 8'h00;
            vconfig     <= 8'h00;  // zx mode, 256x192
            scr_page    <= 8'h00;
        end else begin
            if (reg_wr) begin
                case (reg_addr)
                    reg_vconfig:  vconfig_stg <= reg_data;
                    reg_scr_page: page_stg    <= reg_data;
                endcase
            end
            // live copies only move between frames
            if (frame_start) begin
                vconfig  <= vconfig_stg;
                scr_page <= page_stg;
            end
        end
    end

endmodule

// ==== logic/video_top.sv ====
// video fetch front end top: config registers, raster, mode decoder and fetch scheduler
module video_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        reg_wr,
    input  logic        reg_addr,
    input  logic [7:0]  reg_data,
    output logic        dram_req,
    output logic [20:0] dram_addr,
    output logic [3:0]  dram_sel,
    output logic [1:0]  dram_bsl,
    input  logic [15:0] dram_data,
    input  logic        dram_rdy,
    output logic [1:0]  render_mode,
    output logic        hires,
    output logic        pix_active
);

    logic [7:0]  vconfig;
    logic [7:0]  scr_page;
    logic [8:0]  hcount;
    logic [8:0]  vcount;
    logic        line_start;
    logic        frame_start;
    logic [8:0]  hpix_beg;
    logic [8:0]  hpix_end;
    logic [8:0]  vpix_beg;
    logic [8:0]  vpix_end;
    logic [4:0]  go_offs;
    logic [3:0]  video_bw;
    logic [20:0] video_addr;
    logic [3:0]  fetch_sel;
    logic [1:0]  fetch_bsl;
    logic [8:0]  cnt_col;
    logic [8:0]  cnt_row;
    logic [15:0] txt_char;

    video_regs regs_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_wr      (reg_wr),
        .reg_addr    (reg_addr),
        .reg_data    (reg_data),
        .frame_start (frame_start),
        .vconfig     (vconfig),
        .scr_page    (scr_page)
    );

    video_raster raster_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .hcount      (hcount),
        .vcount      (vcount),
        .line_start  (line_start),
        .frame_start (frame_start)
    );

    video_mode mode_i (
        .vconfig     (vconfig),
        .scr_page    (scr_page),
        .txt_char    (txt_char),
        .cnt_col     (cnt_col),
        .cnt_row     (cnt_row),
        .hpix_beg    (hpix_beg),
        .hpix_end    (hpix_end),
        .vpix_beg    (vpix_beg),
        .vpix_end    (vpix_end),
        .go_offs     (go_offs),
        .fetch_sel   (fetch_sel),
        .fetch_bsl   (fetch_bsl),
        .hires       (hires),
        .render_mode (render_mode),
        .video_addr  (video_addr),
        .video_bw    (video_bw)
    );

    // fetch loop closes through the mode decoder via cnt_col, cnt_row and txt_char
    video_fetch fetch_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .hcount      (hcount),
        .vcount      (vcount),
        .line_start  (line_start),
        .hpix_beg    (hpix_beg),
        .hpix_end    (hpix_end),
        .vpix_beg    (vpix_beg),
        .vpix_end    (vpix_end),
        .go_offs     (go_offs),
        .video_bw    (video_bw),
        .video_addr  (video_addr),
        .fetch_sel   (fetch_sel),
        .fetch_bsl   (fetch_bsl),
        .dram_data   (dram_data),
        .dram_rdy    (dram_rdy),
        .cnt_col     (cnt_col),
        .cnt_row     (cnt_row),
        .txt_char    (txt_char),
        .pix_active  (pix_active),
        .dram_req    (dram_req),
        .dram_addr   (dram_addr),
        .dram_sel    (dram_sel),
        .dram_bsl    (dram_bsl)
    );

endmodule

// ==== verification/tb_clock.sv ====
// testbench clock and reset source, 40 ns clock with reset held for three cycles
module tb_clock (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #2 rst_n = 1'b1;  // released like any other input
    end

endmodule

// ==== verification/video_input.dat ====
# config page requests_per_line first_addr first_line last_line
# hex hex decimal hex decimal decimal
00 05 32 0a000 80 271
0d 28 80 50000 76 275
16 30 160 60000 56 295
1f 1a 180 34000 32 319
04 03 256 06000 80 271
18 01 45 02000 32 319

// ==== verification/video_tb.sv ====
// testbench for video_top: replays vectors from the data file, models the dram, checks fetches
module video_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic clk, rst_n, reg_wr, reg_addr, dram_rdy, dram_req, hires, pix_active;
    logic [7:0] reg_data;
    logic [15:0] dram_data, first_data;
    logic [20:0] dram_addr;
    logic [3:0] dram_sel;
    logic [1:0] dram_bsl, render_mode;
    logic [31:0] lcg_state;
    logic pend;
    int h, v, pend_idx, line_reqs, errs, npass, nfail;
    int cycles = 0;
    int limit = 0;
    logic [7:0] q_cfg[$], q_page[$];
    logic [20:0] q_addr[$];
    int q_cnt[$], q_first[$], q_last[$];

    tb_clock clock_i (.clk(clk), .rst_n(rst_n));

    video_top dut_i (
        .clk(clk), .rst_n(rst_n), .reg_wr(reg_wr), .reg_addr(reg_addr), .reg_data(reg_data),
        .dram_req(dram_req), .dram_addr(dram_addr), .dram_sel(dram_sel), .dram_bsl(dram_bsl),
        .dram_data(dram_data), .dram_rdy(dram_rdy), .render_mode(render_mode),
        .hires(hires), .pix_active(pix_active)
    );

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    // renderer path in bits 2:1 and double pixel rate in bit 0, per mode code
    function automatic logic [2:0] render_for_mode(input logic [2:0] mode);
        case (mode)
            3'd3:    return {2'd3, 1'b0};  // test renderer
            3'd5:    return {2'd1, 1'b0};  // 16 colours
            3'd6:    return {2'd2, 1'b0};  // 256 colours
            3'd2:    return {2'd0, 1'b1};  // zx hi-res
            3'd7:    return {2'd0, 1'b1};  // text
            default: return {2'd0, 1'b0};
        endcase
    endfunction

    // byte lanes and byte select of the n-th fetch of a line, n counted from 1
    function automatic logic [5:0] sel_for_fetch(input logic [2:0] mode, input int n,
                                                 input logic row0);
        if (mode == 3'd7) begin
            case (n % 4)
                1:       return {4'b0011, 2'b10};       // char code
                2:       return {4'b1100, 2'b10};       // attribute
                3:       return {4'b0001, row0, row0};  // glyph 0
                default: return {4'b0010, row0, row0};  // glyph 1
            endcase
        end else begin
            return (n % 2 == 1) ? {4'b0011, 2'b10} : {4'b1100, 2'b10};
        end
    endfunction

    // one clock: drive after the rising edge, sample at the falling edge
    task automatic step(input logic wr, input logic addr, input logic [7:0] data);
        @(posedge clk);
        if (rst_n) begin  // local copy of the raster position
            h = (h == 447) ? 0 : h + 1;
            if (h == 0) v = (v == 319) ? 0 : v + 1;
        end
        #2;
        reg_wr = wr;
        reg_addr = addr;
        reg_data = data;
        dram_rdy = pend;  // answer the request seen last cycle
        dram_data = pend ? lcg_next() : 16'h0000;
        if (pend && pend_idx == 1) first_data = dram_data;
        pend = 1'b0;
        @(negedge clk);
        if (h == 0) line_reqs = 0;
        if (dram_req) begin
            line_reqs++;
            pend = 1'b1;
            pend_idx = line_reqs;
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles, fetch never finished", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int fd, rc, n, f, l, pa_first, pa_last, exp_n;
        string line;
        logic [7:0] c, p;
        logic [20:0] a, prev_addr, exp_a;
        logic [8:0] row;
        logic [5:0] exp_s;
        logic [2:0] exp_r;
        logic seen;
        reg_wr = 1'b0;
        reg_addr = 1'b0;
        reg_data = 8'h00;
        dram_rdy = 1'b0;
        dram_data = 16'h0000;
        first_data = 16'h0000;
        lcg_state = 32'h7e26f56c;
        pend = 1'b0;
        h = 0;
        v = 0;
        line_reqs = 0;
        npass = 0;
        nfail = 0;
        fd = $fopen("verification/video_input.dat", "r");
        if (fd == 0) begin
            $display("cannot open the vector file");
            nfail++;
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc > 0 && line.len() > 0 && line[0] != 8'h23) begin  // skip comment lines
                    if ($sscanf(line, "%h %h %d %h %d %d", c, p, n, a, f, l) == 6) begin
                        q_cfg.push_back(c);
                        q_page.push_back(p);
                        q_cnt.push_back(n);
                        q_addr.push_back(a);
                        q_first.push_back(f);
                        q_last.push_back(l);
                    end
                end
            end
            $fclose(fd);
            if (q_cfg.size() == 0) begin
                $display("the vector file holds no test vectors");
                nfail++;
            end
        end
        limit = q_cfg.size() * 3 * 143360 + 100;

        errs = 0;
        while (!rst_n) begin
            step(1'b0, 1'b0, 8'h00);
            assert (dram_req == 1'b0 && pix_active == 1'b0) else begin
                $display("dram_req or pix_active went high during reset");
                errs++;
            end
        end
        $display("test reset: %s", (errs == 0) ? "pass" : "fail");
        if (errs == 0) npass++; else nfail++;

        prev_addr = 21'h0;  // reset state is zx, page 0
        foreach (q_cfg[t]) begin
            errs = 0;
            while (!(h == 0 && v == 0)) step(1'b0, 1'b0, 8'h00);
            step(1'b1, 1'b0, q_cfg[t]);
            step(1'b1, 1'b1, q_page[t]);
            step(1'b0, 1'b0, 8'h00);
            // rest of this frame still runs the old setup
            seen = 1'b0;
            while (!(h == 0 && v == 0)) begin
                step(1'b0, 1'b0, 8'h00);
                if (dram_req && !seen) begin
                    seen = 1'b1;
                    assert (dram_addr == prev_addr) else begin
                        $display("mismatch dram_addr old frame: got %h expected %h",
                                 dram_addr, prev_addr);
                        errs++;
                    end
                end
            end
            seen = 1'b0;
            pa_first = -1;
            pa_last = -1;
            do begin
                if (pix_active) begin
                    if (pa_first < 0) pa_first = v;
                    pa_last = v;
                end
                if (dram_req && !seen) begin
                    seen = 1'b1;
                    assert (dram_addr == q_addr[t]) else begin
                        $display("mismatch dram_addr first: got %h expected %h",
                                 dram_addr, q_addr[t]);
                        errs++;
                    end
                    exp_r = render_for_mode(q_cfg[t][2:0]);
                    assert ({render_mode, hires} == exp_r) else begin
                        $display("mismatch render_mode hires: got %h %h expected %h %h",
                                 render_mode, hires, exp_r[2:1], exp_r[0]);
                        errs++;
                    end
                end
                if (dram_req) begin
                    row = 9'(v - q_first[t]);
                    exp_s = sel_for_fetch(q_cfg[t][2:0], line_reqs, row[0]);
                    assert ({dram_sel, dram_bsl} == exp_s) else begin
                        $display("mismatch dram_sel dram_bsl line %0d: got %h %h expected %h %h",
                                 v, dram_sel, dram_bsl, exp_s[5:2], exp_s[1:0]);
                        errs++;
                    end
                    // text glyph fetch built from the returned char code
                    if (q_cfg[t][2:0] == 3'd7 && line_reqs == 3) begin
                        exp_a = {q_page[t][7:1], 4'b1000, first_data[7:0], row[2:1]};
                        assert (dram_addr == exp_a) else begin
                            $display("mismatch dram_addr glyph line %0d: got %h expected %h",
                                     v, dram_addr, exp_a);
                            errs++;
                        end
                    end
                end
                if (h == 447) begin
                    exp_n = (v >= q_first[t] && v <= q_last[t]) ? q_cnt[t] : 0;
                    assert (line_reqs == exp_n) else begin
                        $display("mismatch dram_req count line %0d: got %h expected %h",
                                 v, line_reqs, exp_n);
                        errs++;
                    end
                end
                step(1'b0, 1'b0, 8'h00);
            end while (!(h == 0 && v == 0));
            assert (pa_first == q_first[t] && pa_last == q_last[t]) else begin
                $display("mismatch pix_active lines: got %h..%h expected %h..%h",
                         pa_first, pa_last, q_first[t], q_last[t]);
                errs++;
            end
            $display("test %0d cfg %h page %h: %s", t, q_cfg[t], q_page[t],
                     (errs == 0) ? "pass" : "fail");
            if (errs == 0) npass++; else nfail++;
            prev_addr = q_addr[t];
        end
        $display("tests passed %0d failed %0d", npass, nfail);
        if (nfail == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
